//--- src/h264_idct_pkg.sv
`default_nettype none

package h264_idct_pkg;

        localparam int COEF_W    = 16;          // level, coefficient and intermediate width
        localparam int PIX_W     = 10;          // one residual sample
        localparam int ROW_W     = 4 * PIX_W;   // col 0 in the low bits
        localparam int BLK_COEFS = 16;
        localparam int QP_W      = 6;           // qp 0..51

        // scale per (qp mod 6), columns are position class 0, 1, 2
        localparam logic [4:0] level_scale [6][3] = '{
                '{5'd10, 5'd16, 5'd13},
                '{5'd11, 5'd18, 5'd14},
                '{5'd13, 5'd20, 5'd16},
                '{5'd14, 5'd23, 5'd18},
                '{5'd16, 5'd25, 5'd20},
                '{5'd18, 5'd29, 5'd23}
        };

        // reverse zigzag index to block position, encoded as {row, col}
        localparam logic [3:0] rz_pos [16] = '{
                4'd15, 4'd14, 4'd11, 4'd7,
                4'd10, 4'd13, 4'd12, 4'd9,
                4'd6,  4'd3,  4'd2,  4'd5,
                4'd8,  4'd4,  4'd1,  4'd0
        };

        // class 0 both even, class 1 both odd, class 2 mixed
        function automatic logic [1:0] pos_class(input logic [3:0] idx);
                logic [3:0] pos;
                pos = rz_pos[idx];
                if (!pos[2] && !pos[0]) begin
                        return 2'd0;
                end
                if (pos[2] && pos[0]) begin
                        return 2'd1;
                end
                return 2'd2;
        endfunction

endpackage

`default_nettype wire

//--- src/coef_dequant.sv
`timescale 1ns/1ps
`default_nettype none

module coef_dequant #(
        parameter int NUM_LANES = 4
) (
        input  wire                                          CLK,
        input  wire                                          rst_n,
        input  wire                                          in_valid,
        input  wire  [NUM_LANES*h264_idct_pkg::COEF_W-1:0]   in_levels,
        input  wire  [h264_idct_pkg::QP_W-1:0]               qp,
        output logic                                         coef_valid,
        output logic [NUM_LANES*h264_idct_pkg::COEF_W-1:0]   coefs
);

        localparam int CW = h264_idct_pkg::COEF_W;
        localparam logic signed [31:0] MAX_C = 2 ** (CW - 1) - 1;
        localparam logic signed [31:0] MIN_C = -(2 ** (CW - 1));

        logic [3:0]                     idx;            // position within the group
        logic [h264_idct_pkg::QP_W-1:0] qp_q;
        logic [h264_idct_pkg::QP_W-1:0] qp_cur;
        logic [3:0]                     qp_div;
        logic [2:0]                     qp_mod;
        logic [4:0]                     scale;
        logic signed [31:0]             scale_s;
        logic [NUM_LANES*CW-1:0]        sat_all;

        function automatic logic [CW-1:0] sat(input logic signed [31:0] v);
                if (v > MAX_C) begin
                        return CW'(MAX_C);
                end
                if (v < MIN_C) begin
                        return CW'(MIN_C);
                end
                return CW'(v);
        endfunction

        // qp is taken live on the first level, held for the rest
        assign qp_cur  = (idx == 4'd0) ? qp : qp_q;
        assign qp_div  = 4'(qp_cur / 6);
        assign qp_mod  = 3'(qp_cur % 6);
        assign scale   = h264_idct_pkg::level_scale[qp_mod][h264_idct_pkg::pos_class(idx)];
        assign scale_s = {27'd0, scale};

        for (genvar l = 0; l < NUM_LANES; l++) begin : g_scale
                logic signed [CW-1:0] lvl;
                logic signed [31:0]   prod;

                assign lvl  = in_levels[l*CW +: CW];
                assign prod = (lvl * scale_s) <<< qp_div;   // at most 28 bits, no overflow
                assign sat_all[l*CW +: CW] = sat(prod);
        end

        always_ff @(posedge CLK) begin
                if (!rst_n) begin
                        idx        <= '0;
                        coef_valid <= 1'b0;
                end else begin
                        coef_valid <= in_valid;
                        if (in_valid) begin
                                idx <= (idx == 4'(h264_idct_pkg::BLK_COEFS - 1)) ? '0 : idx + 4'd1;
                        end
                end
        end

        always_ff @(posedge CLK) begin
                if (in_valid && idx == 4'd0) begin
                        qp_q <= qp;
                end
                coefs <= sat_all;       // same index for every lane
        end

endmodule

`default_nettype wire

//--- src/idct4x4_lane.sv
`timescale 1ns/1ps
`default_nettype none

module idct4x4_lane (
        input  wire                                CLK,
        input  wire                                rst_n,
        input  wire                                coef_valid,
        input  wire  [h264_idct_pkg::COEF_W-1:0]   coef,        // reverse zigzag order
        output logic                               row_valid,
        output logic [h264_idct_pkg::ROW_W-1:0]    row_data     // col 0 in lsbs
);

        localparam int CW       = h264_idct_pkg::COEF_W;
        localparam int PW       = h264_idct_pkg::PIX_W;
        localparam int ROW0_CNT = 6;    // output count that loads row 0
        localparam int LAST_CNT = 10;   // output count that ends the burst

        logic [3:0]           in_idx;
        logic [3:0]           o_cnt;
        logic [3:0]           wr_pos;
        logic [1:0]           g_col;
        logic [1:0]           h_col;
        logic [1:0]           r_sel;
        logic [CW-1:0]        dm [16];          // block as received, row major
        logic [3:0][CW-1:0]   fm [4];           // row transformed
        logic [3:0][CW-1:0]   gv;               // one column transformed
        logic [PW-1:0]        hm [4][4];        // rounded residuals [row][col]

        // 1-D inverse core, same for rows and columns
        function automatic logic [3:0][CW-1:0] bfly(
                input logic signed [CW-1:0] a0,
                input logic signed [CW-1:0] a1,
                input logic signed [CW-1:0] a2,
                input logic signed [CW-1:0] a3
        );
                logic signed [CW-1:0] e0;
                logic signed [CW-1:0] e1;
                logic signed [CW-1:0] e2;
                logic signed [CW-1:0] e3;
                e0 = a0 + a2;
                e1 = a0 - a2;
                e2 = (a1 >>> 1) - a3;
                e3 = a1 + (a3 >>> 1);
                return {e0 - e3, e1 - e2, e1 + e2, e0 + e3};
        endfunction

        function automatic logic [PW-1:0] rnd(input logic [CW-1:0] v);
                logic [CW-1:0] s;
                s = v + CW'(32);
                return s[CW-1:6];       // low 10 bits after >> 6
        endfunction

        assign wr_pos = h264_idct_pkg::rz_pos[in_idx];
        assign g_col  = 2'(o_cnt - 4'd1);
        assign h_col  = 2'(o_cnt - 4'd2);
        assign r_sel  = 2'(o_cnt - 4'(ROW0_CNT));

        always_ff @(posedge CLK) begin
                if (!rst_n) begin
                        in_idx    <= '0;
                        o_cnt     <= '0;
                        row_valid <= 1'b0;
                end else begin
                        if (coef_valid) begin
                                in_idx <= in_idx + 4'd1;
                        end
                        if (o_cnt == 4'(LAST_CNT)) begin
                                o_cnt <= '0;
                        end else if (o_cnt != 4'd0 ||
                                     (coef_valid && in_idx == 4'(h264_idct_pkg::BLK_COEFS - 1))) begin
                                o_cnt <= o_cnt + 4'd1;
                        end
                        row_valid <= (o_cnt >= 4'(ROW0_CNT)) && (o_cnt < 4'(LAST_CNT));
                end
        end

        always_ff @(posedge CLK) begin
                if (coef_valid) begin
                        dm[wr_pos] <= coef;
                        // col 0 always arrives last in its row
                        if (wr_pos[1:0] == 2'd0) begin
                                fm[wr_pos[3:2]] <= bfly(coef,
                                                        dm[{wr_pos[3:2], 2'd1}],
                                                        dm[{wr_pos[3:2], 2'd2}],
                                                        dm[{wr_pos[3:2], 2'd3}]);
                        end
                end
                if (o_cnt >= 4'd1 && o_cnt <= 4'd4) begin
                        gv <= bfly(fm[0][g_col], fm[1][g_col], fm[2][g_col], fm[3][g_col]);
                end
                if (o_cnt >= 4'd2 && o_cnt <= 4'd5) begin
                        for (int r = 0; r < 4; r++) begin
                                hm[r][h_col] <= rnd(gv[r]);
                        end
                end
                if (o_cnt >= 4'(ROW0_CNT) && o_cnt < 4'(LAST_CNT)) begin
                        row_data <= {hm[r_sel][3], hm[r_sel][2], hm[r_sel][1], hm[r_sel][0]};
                end
        end

        // a block is 16 back-to-back coefficients
        a_no_gap: assert property (@(posedge CLK) disable iff (!rst_n)
                (coef_valid && in_idx != 4'(h264_idct_pkg::BLK_COEFS - 1)) |=> coef_valid);

endmodule

`default_nettype wire

//--- src/row_collector.sv
`timescale 1ns/1ps
`default_nettype none

module row_collector #(
        parameter int NUM_LANES = 4
) (
        input  wire                                          CLK,
        input  wire                                          rst_n,
        input  wire  [NUM_LANES-1:0]                         row_valid_in,
        input  wire  [NUM_LANES*h264_idct_pkg::ROW_W-1:0]    rows_in,
        output logic                                         out_valid,
        output logic [h264_idct_pkg::ROW_W-1:0]              out_row
);

        localparam int RW    = h264_idct_pkg::ROW_W;
        localparam int DEPTH = 4 * NUM_LANES;
        localparam int PTR_W = $clog2(DEPTH);

        logic             cap;
        logic [1:0]       cap_row;              // row number of the current capture
        logic [PTR_W-1:0] rd_ptr;
        logic [RW-1:0]    row_buf [DEPTH];      // lane-major, lane*4 + row
        logic [DEPTH-1:0] unread;
        logic [DEPTH-1:0] cap_mask;
        logic [DEPTH-1:0] rd_mask;

        assign cap     = row_valid_in[0];       // all lanes in step
        assign rd_mask = out_valid ? (DEPTH'(1) << rd_ptr) : '0;
        assign out_row = row_buf[rd_ptr];

        always_comb begin
                cap_mask = '0;
                for (int j = 0; j < NUM_LANES; j++) begin
                        cap_mask[4*j + cap_row] = cap;
                end
        end

        always_ff @(posedge CLK) begin
                if (!rst_n) begin
                        cap_row   <= '0;
                        rd_ptr    <= '0;
                        out_valid <= 1'b0;
                        unread    <= '0;
                end else begin
                        if (cap) begin
                                cap_row <= cap_row + 2'd1;
                        end
                        // a new group restarts the walk, even on the last read
                        if (cap && cap_row == 2'd0) begin
                                rd_ptr    <= '0;
                                out_valid <= 1'b1;
                        end else if (out_valid) begin
                                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                                        out_valid <= 1'b0;
                                end
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        unread <= (unread & ~rd_mask) | cap_mask;
                end
        end

        always_ff @(posedge CLK) begin
                if (cap) begin
                        for (int j = 0; j < NUM_LANES; j++) begin
                                row_buf[4*j + cap_row] <= rows_in[j*RW +: RW];
                        end
                end
        end

        a_lanes_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
                (row_valid_in == '0) || (row_valid_in == '1));

        // a row still waiting for output is never overwritten
        a_no_overrun: assert property (@(posedge CLK) disable iff (!rst_n)
                cap |-> ((unread & ~rd_mask & cap_mask) == '0));

endmodule

`default_nettype wire

//--- src/residual_idct_top.sv
`timescale 1ns/1ps
`default_nettype none

module residual_idct_top #(
        parameter int NUM_LANES = 4
) (
        input  wire                                          CLK,
        input  wire                                          rst_n,
        input  wire                                          in_valid,
        input  wire  [NUM_LANES*h264_idct_pkg::COEF_W-1:0]   in_levels,
        input  wire  [h264_idct_pkg::QP_W-1:0]               qp,
        output wire                                          out_valid,
        output wire  [h264_idct_pkg::ROW_W-1:0]              out_row
);

        localparam int CW = h264_idct_pkg::COEF_W;
        localparam int RW = h264_idct_pkg::ROW_W;

        logic                    coef_valid;    // shared by every lane
        logic [NUM_LANES*CW-1:0] coefs;
        logic [NUM_LANES-1:0]    row_valid;
        logic [NUM_LANES*RW-1:0] rows;

        coef_dequant #(
                .NUM_LANES(NUM_LANES)
        ) u_dequant (
                .CLK       (CLK),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_levels (in_levels),
                .qp        (qp),
                .coef_valid(coef_valid),
                .coefs     (coefs)
        );

        for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
                idct4x4_lane u_lane (
                        .CLK       (CLK),
                        .rst_n     (rst_n),
                        .coef_valid(coef_valid),
                        .coef      (coefs[l*CW +: CW]),
                        .row_valid (row_valid[l]),
                        .row_data  (rows[l*RW +: RW])
                );
        end

        row_collector #(
                .NUM_LANES(NUM_LANES)
        ) u_collector (
                .CLK         (CLK),
                .rst_n       (rst_n),
                .row_valid_in(row_valid),
                .rows_in     (rows),
                .out_valid   (out_valid),
                .out_row     (out_row)
        );

endmodule

`default_nettype wire

//--- testbench/idct_checker.sv
`timescale 1ns/1ps
`default_nettype none

module idct_checker #(
        parameter int ROW_W = 40
) (
        input  wire             CLK,
        input  wire             out_valid,
        input  wire [ROW_W-1:0] out_row,
        input  wire             exp_valid,      // one expected row per cycle
        input  wire [ROW_W-1:0] exp_row,
        input  wire             done,
        output int              mismatches,
        output int              unexpected,
        output int              pending
);

        logic [ROW_W-1:0] exp_q [$];            // oldest row first
        logic [ROW_W-1:0] want;
        int               n_mis = 0;
        int               n_unexp = 0;
        int               n_pend = 0;

        assign mismatches = n_mis;
        assign unexpected = n_unexp;
        assign pending    = n_pend;

        // sampled on the falling edge
        always @(negedge CLK) begin
                if (exp_valid) begin
                        exp_q.push_back(exp_row);
                end
                if (out_valid) begin
                        if (exp_q.size() == 0) begin
                                $display("out_valid at %0t ns while no row was expected", $time);
                                n_unexp++;
                        end else begin
                                want = exp_q.pop_front();
                                if (out_row !== want) begin
                                        $display("CHECK FAILED out_row expected %h got %h", want,
                                                 out_row);
                                        n_mis++;
                                end
                        end
                end
                n_pend = exp_q.size();
        end

        always @(posedge done) begin
                if (exp_q.size() != 0) begin
                        $display("%0d expected rows never came out of the DUT", exp_q.size());
                end
        end

endmodule

`default_nettype wire

//--- testbench/tb_residual_idct.sv
`timescale 1ns/1ps
`default_nettype none

module tb_residual_idct;

        localparam int LANES           = 4;     // 4 rows per lane, 16 rows per group
        localparam int CW              = h264_idct_pkg::COEF_W;
        localparam int PW              = h264_idct_pkg::PIX_W;
        localparam int RW              = h264_idct_pkg::ROW_W;
        localparam int NUM_GROUPS      = 34;
        localparam int WATCHDOG_CYCLES = NUM_GROUPS * 40 + 400;

        // zigzag scan, entry is row * 4 + col
        localparam int ZIGZAG [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};
        localparam int SCALE [6][3] = '{'{10, 16, 13}, '{11, 18, 14}, '{13, 20, 16},
                                        '{14, 23, 18}, '{16, 25, 20}, '{18, 29, 23}};
        localparam int FIXED_QP [5] = '{0, 5, 6, 28, 51};

        logic                CLK;
        logic                rst_n;
        logic                in_valid;
        logic [LANES*CW-1:0] in_levels;
        logic [5:0]          qp;
        wire                 out_valid;
        wire  [RW-1:0]       out_row;
        logic                exp_valid;
        logic [RW-1:0]       exp_row;
        logic                done;
        int                  mismatches;
        int                  unexpected;
        int                  pending;
        logic [31:0]         lfsr = 32'h7458_54fb;
        logic [CW-1:0]       grp_lv [LANES][16];        // reverse zigzag order
        logic [5:0]          grp_qp;

        residual_idct_top #(
                .NUM_LANES(LANES)
        ) u_dut (
                .CLK      (CLK),
                .rst_n    (rst_n),
                .in_valid (in_valid),
                .in_levels(in_levels),
                .qp       (qp),
                .out_valid(out_valid),
                .out_row  (out_row)
        );

        idct_checker #(
                .ROW_W(RW)
        ) u_checker (
                .CLK       (CLK),
                .out_valid (out_valid),
                .out_row   (out_row),
                .exp_valid (exp_valid),
                .exp_row   (exp_row),
                .done      (done),
                .mismatches(mismatches),
                .unexpected(unexpected),
                .pending   (pending)
        );

        initial begin
                CLK = 1'b0;
                forever #10 CLK = ~CLK;
        end

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        v    = {v[30:0], lfsr[0]};
                        lfsr = lfsr_next(lfsr);
                end
                return v;
        endfunction

        // expected residual rows of one lane, row r at bits [r*RW +: RW]
        function automatic logic [4*RW-1:0] ref_block(input logic [16*CW-1:0] lv, input int q);
                logic signed [CW-1:0] c [4][4];         // [row][col]
                logic signed [CW-1:0] x [4];
                logic signed [CW-1:0] e [4];
                logic [CW-1:0]        s;
                logic [4*RW-1:0]      res;
                int                   pos;
                int                   cls;
                longint               v;
                for (int i = 0; i < 16; i++) begin
                        pos = ZIGZAG[15 - i];
                        cls = ((pos / 4) % 2 == pos % 2) ? pos % 2 : 2;
                        v   = longint'($signed(lv[i*CW +: CW])) * SCALE[q % 6][cls];
                        v   = v * (longint'(1) << (q / 6));
                        if (v > 32767) begin
                                v = 32767;
                        end else if (v < -32768) begin
                                v = -32768;
                        end
                        c[pos / 4][pos % 4] = CW'(v);
                end
                // rows first, then columns, all in 16-bit wrap
                for (int p = 0; p < 2; p++) begin
                        for (int i = 0; i < 4; i++) begin
                                for (int k = 0; k < 4; k++) begin
                                        x[k] = (p == 0) ? c[i][k] : c[k][i];
                                end
                                e[0] = x[0] + x[2];
                                e[1] = x[0] - x[2];
                                e[2] = (x[1] >>> 1) - x[3];
                                e[3] = x[1] + (x[3] >>> 1);
                                x[0] = e[0] + e[3];
                                x[1] = e[1] + e[2];
                                x[2] = e[1] - e[2];
                                x[3] = e[0] - e[3];
                                for (int k = 0; k < 4; k++) begin
                                        if (p == 0) begin
                                                c[i][k] = x[k];
                                        end else begin
                                                c[k][i] = x[k];
                                        end
                                end
                        end
                end
                for (int r = 0; r < 4; r++) begin
                        for (int k = 0; k < 4; k++) begin
                                s = c[r][k] + CW'(32);
                                res[r*RW + k*PW +: PW] = s[CW-1:6];     // low 10 bits of >> 6
                        end
                end
                return res;
        endfunction

        // mode 0 zeros, 1 lone DC of 64, 2 small random, 3 full range
        task automatic make_group(input int mode, input logic [5:0] q);
                logic [31:0] b;
                for (int l = 0; l < LANES; l++) begin
                        for (int i = 0; i < 16; i++) begin
                                case (mode)
                                        0: grp_lv[l][i] = 16'd0;
                                        1: grp_lv[l][i] = (i == 15) ? 16'd64 : 16'd0;  // DC comes last
                                        2: begin
                                                b = take_bits(6);
                                                grp_lv[l][i] = {{10{b[5]}}, b[5:0]};
                                        end
                                        default: grp_lv[l][i] = CW'(take_bits(16));
                                endcase
                        end
                end
                grp_qp = q;
        endtask

        task automatic send_group(input int ncyc, input bit keep);
                logic [16*CW-1:0] pk;
                logic [4*RW-1:0]  blk;
                logic [RW-1:0]    rows [16];
                for (int l = 0; l < LANES; l++) begin
                        for (int i = 0; i < 16; i++) begin
                                pk[i*CW +: CW] = grp_lv[l][i];
                        end
                        blk = ref_block(pk, int'(grp_qp));
                        for (int r = 0; r < 4; r++) begin
                                rows[l*4 + r] = blk[r*RW +: RW];        // lane-major
                        end
                end
                for (int k = 0; k < ncyc; k++) begin
                        @(posedge CLK);
                        #2;
                        in_valid = 1'b1;
                        qp       = (k == 0) ? grp_qp : 6'(take_bits(6));  // only first cycle counts
                        for (int l = 0; l < LANES; l++) begin
                                in_levels[l*CW +: CW] = grp_lv[l][k];
                        end
                        exp_valid = keep;
                        exp_row   = rows[k];
                end
        endtask

        task automatic idle(input int n);
                repeat (n) begin
                        @(posedge CLK);
                        #2;
                        in_valid  = 1'b0;
                        exp_valid = 1'b0;
                end
        endtask

        task automatic drain();
                idle(1);
                while (pending != 0) begin
                        idle(1);
                end
                idle(2);
        endtask

        initial begin
                rst_n     = 1'b0;
                in_valid  = 1'b0;
                in_levels = '0;
                qp        = '0;
                exp_valid = 1'b0;
                exp_row   = '0;
                done      = 1'b0;
                repeat (3) @(posedge CLK);
                #2;
                rst_n = 1'b1;
                idle(2);
                // zero block, then DC only
                make_group(0, 6'd0);
                send_group(16, 1'b1);
                make_group(1, 6'd0);
                send_group(16, 1'b1);
                drain();
                // fixed and random qp
                for (int i = 0; i < 10; i++) begin
                        make_group(2, (i < 5) ? 6'(FIXED_QP[i]) : 6'(take_bits(6) % 52));
                        send_group(16, 1'b1);
                        idle(3);
                end
                drain();
                for (int i = 0; i < 8; i++) begin
                        make_group(2, 6'(take_bits(6) % 52));
                        send_group(16, 1'b1);
                end
                drain();
                for (int i = 0; i < 8; i++) begin
                        make_group(2, 6'(take_bits(6) % 52));
                        send_group(16, 1'b1);
                        idle(int'(take_bits(4)));
                end
                drain();
                // saturated coefficients, wrapped samples
                for (int i = 0; i < 4; i++) begin
                        make_group(3, (i % 2 == 0) ? 6'd51 : 6'(take_bits(6) % 52));
                        send_group(16, 1'b1);
                end
                drain();
                // partial group cut by reset, no rows expected from it
                make_group(2, 6'd20);
                send_group(8, 1'b0);
                @(posedge CLK);
                #2;
                rst_n    = 1'b0;
                in_valid = 1'b0;
                repeat (3) @(posedge CLK);
                #2;
                rst_n = 1'b1;
                idle(30);
                make_group(2, 6'd33);
                send_group(16, 1'b1);
                drain();
                done = 1'b1;
                idle(1);
                $display("errors: %0d mismatched, %0d unexpected, %0d missing rows",
                         mismatches, unexpected, pending);
                if (mismatches == 0 && unexpected == 0 && pending == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge CLK);
                $display("watchdog expired after %0d cycles, the run did not finish",
                         WATCHDOG_CYCLES);
                $display("Testbench failed");
                $finish;
        end

endmodule

`default_nettype wire

//--- files.f
src/h264_idct_pkg.sv
src/coef_dequant.sv
src/idct4x4_lane.sv
src/row_collector.sv
src/residual_idct_top.sv
testbench/idct_checker.sv
testbench/tb_residual_idct.sv

//--- Makefile
sim:
	verilator --binary --assert -Wno-fatal --top-module tb_residual_idct -f files.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_residual_idct)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
